// File: mem_ctrl_cases.txt
// tid func size adr dat expected_res expected_fault, all hex
// func 0 load, 1 loadz, 2 store, 3 lea, others fault; size 0 b, 1 w, 2 t, 3 o
0 0 0 00000080 0000000000000000 FFFFFFFFFFFFFFDA 0
1 1 0 00000080 0000000000000000 00000000000000DA 0
2 0 1 00000082 0000000000000000 FFFFFFFFFFFFD9D8 0
3 1 1 00000082 0000000000000000 000000000000D9D8 0
4 0 2 00000084 0000000000000000 FFFFFFFFDDDCDFDE 0
5 1 2 00000084 0000000000000000 00000000DDDCDFDE 0
6 0 3 00000088 0000000000000000 D5D4D7D6D1D0D3D2 0
7 1 3 00000088 0000000000000000 D5D4D7D6D1D0D3D2 0
8 0 1 00000012 0000000000000000 0000000000004948 0
9 0 0 00000017 0000000000000000 000000000000004D 0
A 2 2 00000044 1122334489ABCDEF 0000000000000000 0
B 0 3 00000040 0000000000000000 89ABCDEF19181B1A 0
C 0 1 00000046 0000000000000000 FFFFFFFFFFFF89AB 0
D 2 0 00000041 0000000000000077 0000000000000000 0
E 1 2 00000040 0000000000000000 000000001918771A 0
F 0 0 00000045 0000000000000000 FFFFFFFFFFFFFFCD 0
0 2 1 00000042 000000000000BEEF 0000000000000000 0
1 1 3 00000040 0000000000000000 89ABCDEFBEEF771A 0
2 0 3 00000005 0000000000000000 56515053525D5C5F 0
3 0 2 0000000E 0000000000000000 000000004B4A5554 0
4 2 3 00000065 0123456789ABCDEF 0000000000000000 0
5 0 3 00000060 0000000000000000 ABCDEF3E39383B3A 0
6 0 3 00000068 0000000000000000 3534370123456789 0
7 0 1 00000067 0000000000000000 FFFFFFFFFFFF89AB 0
8 1 2 00000066 0000000000000000 000000006789ABCD 0
9 2 1 00000087 000000000000A55A 0000000000000000 0
A 0 1 00000087 0000000000000000 FFFFFFFFFFFFA55A 0
B 0 0 00000088 0000000000000000 FFFFFFFFFFFFFFA5 0
C 3 3 12345678 0000000000000000 0000000012345678 0
D 3 0 FFFFFFF1 0000000000000000 00000000FFFFFFF1 0
E 5 0 00000040 0000000000000000 0000000000000000 1
F 7 3 00000040 0000000000000000 0000000000000000 1
0 4 2 00000010 0000000000000000 0000000000000000 1
1 0 0 00000040 0000000000000000 000000000000001A 0

// File: build.f
+incdir+.
mem_ctrl_pkg.sv
mem_queue.sv
mem_lane_align.sv
mem_access_seq.sv
mem_bus_master.sv
mem_ctrl_top.sv
tb_mem_ctrl.sv

// File: tb_mem_ctrl.sv
// testbench for the load/store memory controller
// replays requests from the case file against a byte-wide bus slave
// model, then fills both queues to check back-pressure and ordering

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module tb_mem_ctrl;

	localparam int CASE_COLS    = 7;                   // tid func size adr dat res fault
	localparam int MAX_CASES    = 64;
	localparam int BURST_N      = 2 * `MC_QDEPTH + 1;  // both queues plus one in flight
	localparam int RST_CYCLES   = 8;
	localparam int CYC_PER_CASE = 200;

	logic                    clk;
	logic                    rst;
	mem_ctrl_pkg::mem_req_t  req;
	logic                    req_wr;
	logic                    req_full;
	mem_ctrl_pkg::mem_resp_t resp;
	logic                    resp_rd;
	logic                    resp_empty;
	mem_ctrl_pkg::bus_cmd_t  bus;
	logic                    bus_ack;
	logic [`MC_DWID-1:0]     bus_dat;

	logic [63:0] case_mem [0:CASE_COLS*MAX_CASES-1];
	logic [7:0]  slave_mem [0:255];
	int          n_cases;
	int          cycles = 0;
	int          cycle_limit;
	int          seed;

	// access under test, watched by the slave
	logic [2:0]  cur_func;
	logic [1:0]  cur_size;
	logic [31:0] cur_adr;
	int          beats_seen;

	mem_ctrl_top UUT (
		.clk          (clk),
		.rst          (rst),
		.req_i        (req),
		.req_wr_i     (req_wr),
		.req_full_o   (req_full),
		.resp_o       (resp),
		.resp_rd_i    (resp_rd),
		.resp_empty_o (resp_empty),
		.bus_o        (bus),
		.bus_ack_i    (bus_ack),
		.bus_dat_i    (bus_dat)
	);

	always #10 clk = ~clk;

	// ========================================
	// reporting
	// ========================================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycles));
	end

	// ========================================
	// access rules
	// ========================================
	function automatic int bytes_for(input logic [1:0] size);
		return 1 << size;
	endfunction

	function automatic int beats_for(input logic [2:0] func, input logic [1:0] size,
			input logic [31:0] adr);
		if (func != `MC_F_LOAD && func != `MC_F_LOADZ && func != `MC_F_STORE)
			return 0;   // LEA and unknown codes stay off the bus
		return (int'(adr[2:0]) + bytes_for(size) > 8) ? 2 : 1;
	endfunction

	function automatic logic [31:0] lea_adr(input int i);
		return 32'hC000_0000 + 32'(i) * 32'h10;
	endfunction

	// ========================================
	// bus slave, 256 bytes little endian
	// ========================================
	always begin : bus_slave
		int          wait_cyc;
		logic [7:0]  exp_sel;
		logic [31:0] ba;
		logic [31:0] exp_adr;
		logic [7:0]  idx;
		@(negedge clk);
		if (!rst && bus.cyc && bus.stb) begin
			if (beats_for(cur_func, cur_size, cur_adr) == 0)
				abort_run("bus cycle seen for an access that must not use the bus");
			exp_sel = '0;
			for (int k = 0; k < bytes_for(cur_size); k++) begin
				ba = cur_adr + 32'(k);
				if (ba[31:3] == bus.adr[31:3])
					exp_sel[ba[2:0]] = 1'b1;   // byte falls in this beat's word
			end
			exp_adr = {cur_adr[31:3], 3'b000} + 32'(8 * beats_seen);
			check("bus adr", exp_adr, bus.adr);
			check("bus sel", exp_sel, bus.sel);
			check("bus we", cur_func == `MC_F_STORE, bus.we);
			wait_cyc = $urandom % 4;   // ack stall 0..3
			repeat (wait_cyc) @(negedge clk);
			for (int l = 0; l < 8; l++) begin
				idx = bus.adr[7:0] + 8'(l);
				if (bus.we && bus.sel[l])
					slave_mem[idx] = bus.dat[8*l +: 8];
				bus_dat[8*l +: 8] = slave_mem[idx];
			end
			beats_seen++;
			bus_ack = 1'b1;
			while (bus.stb) @(negedge clk);
			bus_ack = 1'b0;
		end
	end

	// ========================================
	// stimulus
	// ========================================
	task automatic send_req(input logic [3:0] tid, input logic [2:0] func,
			input logic [1:0] size, input logic [31:0] adr, input logic [63:0] dat);
		req.tid  = tid;
		req.func = mem_ctrl_pkg::mem_func_e'(func);
		req.size = mem_ctrl_pkg::mem_size_e'(size);
		req.adr  = adr;
		req.dat  = dat;
		req_wr   = 1'b1;
	endtask

	// one request, wait for its response, read it out
	task automatic run_case(input int c);
		int    base;
		string name;
		base     = c * CASE_COLS;
		name     = $sformatf("case %0d", c);
		cur_func = case_mem[base+1][2:0];
		cur_size = case_mem[base+2][1:0];
		cur_adr  = case_mem[base+3][31:0];
		beats_seen = 0;
		send_req(case_mem[base][3:0], cur_func, cur_size, cur_adr, case_mem[base+4]);
		@(negedge clk);
		req_wr = 1'b0;
		while (resp_empty) @(negedge clk);
		check({name, " tid"}, case_mem[base], resp.tid);
		check({name, " res"}, case_mem[base+5], resp.res);
		check({name, " fault"}, case_mem[base+6], resp.fault);
		check({name, " bus beats"}, beats_for(cur_func, cur_size, cur_adr), beats_seen);
		resp_rd = 1'b1;
		@(negedge clk);
		resp_rd = 1'b0;
	endtask

	// LEA burst with reads held off, then drain in order
	task automatic fill_and_drain();
		int sent;
		sent       = 0;
		cur_func   = `MC_F_LEA;
		beats_seen = 0;
		while (sent < BURST_N) begin
			if (!req_full) begin
				send_req(4'(sent), `MC_F_LEA, `MC_SZ_O, lea_adr(sent), 64'h0);
				sent++;
			end else
				req_wr = 1'b0;
			@(negedge clk);
		end
		req_wr = 1'b0;
		while (!req_full) @(negedge clk);
		check("fill resp_empty", 0, resp_empty);
		for (int i = 0; i < BURST_N; i++) begin
			while (resp_empty) @(negedge clk);
			check($sformatf("drain %0d tid", i), i, resp.tid);
			check($sformatf("drain %0d res", i), lea_adr(i), resp.res);
			check($sformatf("drain %0d fault", i), 0, resp.fault);
			resp_rd = 1'b1;
			@(negedge clk);
			resp_rd = 1'b0;
		end
		check("drain resp_empty", 1, resp_empty);
		check("drain req_full", 0, req_full);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		req        = '0;
		req_wr     = 1'b0;
		resp_rd    = 1'b0;
		bus_ack    = 1'b0;
		bus_dat    = '0;
		cur_func   = `MC_F_LEA;
		cur_size   = `MC_SZ_B;
		cur_adr    = '0;
		beats_seen = 0;
		seed       = 34441;
		void'($urandom(seed));
		for (int a = 0; a < 256; a++)
			slave_mem[a] = 8'(a) ^ 8'h5A;
		for (int i = 0; i < CASE_COLS * MAX_CASES; i++)
			case_mem[i] = '1;   // end marker, tids are only 4 bits
		$readmemh("mem_ctrl_cases.txt", case_mem);
		n_cases = 0;
		while (n_cases < MAX_CASES && case_mem[n_cases*CASE_COLS] !== '1)
			n_cases++;
		cycle_limit = RST_CYCLES + CYC_PER_CASE * (n_cases + BURST_N);
		if (n_cases == 0)
			abort_run("no cases could be read from mem_ctrl_cases.txt");

		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		check("reset cyc", 0, bus.cyc);
		check("reset stb", 0, bus.stb);
		check("reset we", 0, bus.we);
		check("reset sel", 0, bus.sel);
		check("reset req_full", 0, req_full);
		check("reset resp_empty", 1, resp_empty);

		for (int c = 0; c < n_cases; c++)
			run_case(c);
		fill_and_drain();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_ctrl_top.sv
// load/store memory controller top level
// request queue, access sequencer, bus master and response queue

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module mem_ctrl_top (
	input  wire                               clk,
	input  wire                               rst,
	input  wire mem_ctrl_pkg::mem_req_t       req_i,
	input  wire                               req_wr_i,
	output logic                              req_full_o,
	output mem_ctrl_pkg::mem_resp_t           resp_o,
	input  wire                               resp_rd_i,
	output logic                              resp_empty_o,
	output mem_ctrl_pkg::bus_cmd_t            bus_o,
	input  wire                               bus_ack_i,
	input  wire                [`MC_DWID-1:0] bus_dat_i
);

	mem_ctrl_pkg::mem_req_t   head_req;
	mem_ctrl_pkg::mem_resp_t  seq_resp;
	logic                     req_empty;
	logic                     req_pop;
	logic                     resp_full;
	logic                     resp_push;
	logic                     beat_req;
	logic                     beat_hi;
	logic                     beat_ack;
	logic [`MC_DWID-1:0]      rd_word;
	logic [`MC_SELW-1:0]      sel;
	logic [`MC_DWID-1:0]      st_word;
	logic [`MC_AWID-1:0]      adr;
	logic                     we;

	mem_queue #(.payload_t(mem_ctrl_pkg::mem_req_t)) u_req_q (
		.clk, .rst,
		.push_i (req_wr_i), .data_i (req_i), .pop_i (req_pop),
		.data_o (head_req), .full_o (req_full_o), .empty_o (req_empty)
	);

	mem_access_seq u_seq (
		.clk, .rst,
		.req_i (head_req), .req_empty_i (req_empty), .pop_o (req_pop),
		.resp_o (seq_resp), .resp_full_i (resp_full), .push_o (resp_push),
		.beat_req_o (beat_req), .beat_hi_o (beat_hi), .beat_ack_i (beat_ack),
		.rd_word_i (rd_word), .sel_o (sel), .st_word_o (st_word),
		.adr_o (adr), .we_o (we)
	);

	mem_bus_master u_bus (
		.clk, .rst,
		.beat_req_i (beat_req), .beat_hi_i (beat_hi), .adr_i (adr), .we_i (we),
		.sel_i (sel), .st_word_i (st_word), .beat_ack_o (beat_ack),
		.rd_word_o (rd_word), .bus_o (bus_o), .bus_ack_i (bus_ack_i), .bus_dat_i (bus_dat_i)
	);

	mem_queue #(.payload_t(mem_ctrl_pkg::mem_resp_t)) u_resp_q (
		.clk, .rst,
		.push_i (resp_push), .data_i (seq_resp), .pop_i (resp_rd_i),
		.data_o (resp_o), .full_o (resp_full), .empty_o (resp_empty_o)
	);

endmodule

`default_nettype wire

// File: mem_bus_master.sv
// bus master for a single beat
// registers the command and runs the stb/ack cycle: raise cyc+stb,
// wait for ack, drop, wait for ack low, then report the beat done

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module mem_bus_master (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      beat_req_i,
	input  wire                      beat_hi_i,
	input  wire       [`MC_AWID-1:0] adr_i,
	input  wire                      we_i,
	input  wire       [`MC_SELW-1:0] sel_i,
	input  wire       [`MC_DWID-1:0] st_word_i,
	output logic                     beat_ack_o,
	output logic      [`MC_DWID-1:0] rd_word_o,
	output mem_ctrl_pkg::bus_cmd_t   bus_o,
	input  wire                      bus_ack_i,
	input  wire       [`MC_DWID-1:0] bus_dat_i
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_STB,    // waiting for ack high
		M_REL,    // waiting for ack low
		M_DONE    // beat_ack up until beat_req drops
	} bm_state_e;

	bm_state_e            state;
	logic                 cyc_q;
	logic                 stb_q;
	logic                 we_q;
	logic [`MC_SELW-1:0]  sel_q;
	logic [`MC_AWID-1:0]  adr_q;
	logic [`MC_DWID-1:0]  dat_q;
	logic [`MC_AWID-1:0]  beat_adr;

	// word aligned, next word for the spill-over beat
	assign beat_adr = {adr_i[`MC_AWID-1:3], 3'b000} + (beat_hi_i ? `MC_AWID'(8) : '0);

	always_comb begin
		bus_o.cyc = cyc_q;
		bus_o.stb = stb_q;
		bus_o.we  = we_q;
		bus_o.sel = sel_q;
		bus_o.adr = adr_q;
		bus_o.dat = dat_q;
	end

	// ========================================
	// cycle control
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= M_IDLE;
			cyc_q      <= 1'b0;
			stb_q      <= 1'b0;
			we_q       <= 1'b0;
			sel_q      <= '0;
			beat_ack_o <= 1'b0;
		end else begin
			case (state)
			M_IDLE:
				if (beat_req_i) begin
					cyc_q <= 1'b1;
					stb_q <= 1'b1;
					we_q  <= we_i;
					sel_q <= sel_i;
					state <= M_STB;
				end
			M_STB:
				if (bus_ack_i) begin   // slave may stall here
					cyc_q <= 1'b0;
					stb_q <= 1'b0;
					we_q  <= 1'b0;
					sel_q <= '0;
					state <= M_REL;
				end
			M_REL:
				if (!bus_ack_i) begin
					beat_ack_o <= 1'b1;
					state      <= M_DONE;
				end
			M_DONE:
				if (!beat_req_i) begin
					beat_ack_o <= 1'b0;
					state      <= M_IDLE;
				end
			default: state <= M_IDLE;
			endcase
		end
	end

	// address, store data and captured read word
	always_ff @(posedge clk) begin
		if (state == M_IDLE && beat_req_i) begin
			adr_q <= beat_adr;
			dat_q <= st_word_i;
		end
		if (state == M_STB && bus_ack_i)
			rd_word_o <= bus_dat_i;
	end

	// slave only answers a strobe that is up
	a_ack_on_stb: assert property (@(posedge clk) disable iff (rst)
		$rose(bus_ack_i) |-> bus_o.stb);
	// request held until the beat is acknowledged
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		beat_req_i && !beat_ack_o |=> beat_req_i);

endmodule

`default_nettype wire

// File: mem_access_seq.sv
// access sequencer
// takes one request from the queue, runs one or two bus beats
// through the bus master and builds the response

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module mem_access_seq (
	input  wire                                clk,
	input  wire                                rst,
	input  wire mem_ctrl_pkg::mem_req_t        req_i,
	input  wire                                req_empty_i,
	output logic                               pop_o,
	output mem_ctrl_pkg::mem_resp_t            resp_o,
	input  wire                                resp_full_i,
	output logic                               push_o,
	output logic                               beat_req_o,
	output logic                               beat_hi_o,
	input  wire                                beat_ack_i,
	input  wire                 [`MC_DWID-1:0] rd_word_i,
	output logic                [`MC_SELW-1:0] sel_o,
	output logic                [`MC_DWID-1:0] st_word_o,
	output logic                [`MC_AWID-1:0] adr_o,
	output logic                               we_o
);

	typedef enum logic [2:0] {
		ST_IDLE, ST_LATCH, ST_BEAT, ST_WAIT_REL, ST_RESPOND
	} seq_state_e;

	seq_state_e             state;
	mem_ctrl_pkg::mem_req_t req_q;
	logic [`MC_DWID-1:0]    lo_word;
	logic [`MC_DWID-1:0]    hi_word;
	logic [`MC_DWID-1:0]    ld_res;
	logic                   two_beat;
	logic                   need_hi;

	mem_lane_align u_align (
		.adr_i      (req_q.adr),
		.size_i     (req_q.size),
		.zext_i     (req_q.func == mem_ctrl_pkg::FN_LOADZ),
		.st_dat_i   (req_q.dat),
		.beat_hi_i  (beat_hi_o),
		.lo_word_i  (lo_word),
		.hi_word_i  (hi_word),
		.sel_o      (sel_o),
		.st_word_o  (st_word_o),
		.ld_res_o   (ld_res),
		.two_beat_o (two_beat)
	);

	assign adr_o   = req_q.adr;
	assign we_o    = (req_q.func == mem_ctrl_pkg::FN_STORE);
	assign need_hi = two_beat & ~beat_hi_o;   // low beat done, high still owed
	assign push_o  = (state == ST_RESPOND) && !resp_full_i;

	// ========================================
	// control FSM
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			pop_o      <= 1'b0;
			beat_req_o <= 1'b0;
			beat_hi_o  <= 1'b0;
		end else begin
			pop_o <= 1'b0;
			case (state)
			ST_IDLE:
				if (!req_empty_i) begin
					pop_o <= 1'b1;   // head already copied into req_q
					state <= ST_LATCH;
				end
			ST_LATCH:
				case (req_q.func)
				mem_ctrl_pkg::FN_LOAD, mem_ctrl_pkg::FN_LOADZ, mem_ctrl_pkg::FN_STORE: begin
					beat_hi_o  <= 1'b0;
					beat_req_o <= 1'b1;
					state      <= ST_BEAT;
				end
				default: state <= ST_RESPOND;   // LEA and faults skip the bus
				endcase
			ST_BEAT:
				if (beat_ack_i) begin
					beat_req_o <= 1'b0;
					state      <= ST_WAIT_REL;
				end
			ST_WAIT_REL:
				if (!beat_ack_i) begin
					if (need_hi) begin
						beat_hi_o  <= 1'b1;
						beat_req_o <= 1'b1;
						state      <= ST_BEAT;
					end else
						state <= ST_RESPOND;
				end
			ST_RESPOND:
				if (push_o) state <= ST_IDLE;   // held here while resp queue full
			default: state <= ST_IDLE;
			endcase
		end
	end

	// ========================================
	// request, read words and response
	// ========================================
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && !req_empty_i)
			req_q <= req_i;
		if (state == ST_BEAT && beat_ack_i) begin
			if (beat_hi_o) hi_word <= rd_word_i;
			else           lo_word <= rd_word_i;
		end
		if (state == ST_LATCH) begin
			resp_o.tid <= req_q.tid;
			case (req_q.func)
			mem_ctrl_pkg::FN_LEA: begin
				resp_o.fault <= 1'b0;
				resp_o.res   <= `MC_DWID'(req_q.adr);
			end
			mem_ctrl_pkg::FN_LOAD, mem_ctrl_pkg::FN_LOADZ, mem_ctrl_pkg::FN_STORE:
				resp_o.fault <= 1'b0;
			default: begin
				resp_o.fault <= 1'b1;   // unimplemented operation
				resp_o.res   <= '0;
			end
			endcase
		end
		if (state == ST_WAIT_REL && !beat_ack_i && !need_hi)
			resp_o.res <= we_o ? '0 : ld_res;
	end

	// the bus master only acknowledges a beat that was requested
	a_ack_on_req: assert property (@(posedge clk) disable iff (rst)
		$rose(beat_ack_i) |-> beat_req_o);

endmodule

`default_nettype wire

// File: mem_lane_align.sv
// byte lane alignment
// builds the lane select and shifted store word for either beat
// and extracts a sign or zero extended load result from two words

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module mem_lane_align (
	input  wire                        [`MC_AWID-1:0] adr_i,
	input  wire mem_ctrl_pkg::mem_size_e              size_i,
	input  wire                                       zext_i,
	input  wire                        [`MC_DWID-1:0] st_dat_i,
	input  wire                                       beat_hi_i,
	input  wire                        [`MC_DWID-1:0] lo_word_i,
	input  wire                        [`MC_DWID-1:0] hi_word_i,
	output logic                       [`MC_SELW-1:0] sel_o,
	output logic                       [`MC_DWID-1:0] st_word_o,
	output logic                       [`MC_DWID-1:0] ld_res_o,
	output logic                                      two_beat_o
);

	logic [2:0]              ofs;         // byte offset in the word
	logic [`MC_SELW-1:0]     size_mask;
	logic [3:0]              nbytes;
	logic [2*`MC_SELW-1:0]   lane16;      // lanes over both beats
	logic [2*`MC_DWID-1:0]   st_wide;
	logic [2*`MC_DWID-1:0]   ld_wide;
	logic                    sgn;

	assign ofs = adr_i[2:0];
	assign sgn = ~zext_i;

	always_comb begin
		case (size_i)
		mem_ctrl_pkg::SZ_B: begin size_mask = 8'h01; nbytes = 4'd1; end
		mem_ctrl_pkg::SZ_W: begin size_mask = 8'h03; nbytes = 4'd2; end
		mem_ctrl_pkg::SZ_T: begin size_mask = 8'h0F; nbytes = 4'd4; end
		default:            begin size_mask = 8'hFF; nbytes = 4'd8; end
		endcase
	end

	// ========================================
	// store side
	// ========================================
	assign lane16  = {8'h00, size_mask} << ofs;
	assign st_wide = {{`MC_DWID{1'b0}}, st_dat_i} << {ofs, 3'b000};

	assign sel_o     = beat_hi_i ? lane16[15:8] : lane16[7:0];
	assign st_word_o = beat_hi_i ? st_wide[127:64] : st_wide[63:0];

	// spills into the next word
	assign two_beat_o = ({1'b0, ofs} + nbytes) > 4'd8;

	// ========================================
	// load side
	// ========================================
	assign ld_wide = {hi_word_i, lo_word_i} >> {ofs, 3'b000};

	always_comb begin
		case (size_i)
		mem_ctrl_pkg::SZ_B: ld_res_o = {{56{sgn & ld_wide[7]}}, ld_wide[7:0]};
		mem_ctrl_pkg::SZ_W: ld_res_o = {{48{sgn & ld_wide[15]}}, ld_wide[15:0]};
		mem_ctrl_pkg::SZ_T: ld_res_o = {{32{sgn & ld_wide[31]}}, ld_wide[31:0]};
		default:            ld_res_o = ld_wide[63:0];   // octa, nothing to extend
		endcase
	end

endmodule

`default_nettype wire

// File: mem_queue.sv
// first-word-fall-through queue
// circular buffer with registered full/empty flags, the head entry
// is always visible on data_o

`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_params.svh"

module mem_queue #(
	parameter type payload_t = logic [7:0]
) (
	input  wire           clk,
	input  wire           rst,
	input  wire           push_i,
	input  wire payload_t data_i,
	input  wire           pop_i,
	output payload_t      data_o,
	output logic          full_o,
	output logic          empty_o
);

	localparam int DEPTH = `MC_QDEPTH;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW    = AW + 1;

	payload_t       mem_q [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [CW-1:0]  count;

	wire do_push = push_i & ~full_o;   // writes into a full queue are dropped
	wire do_pop  = pop_i & ~empty_o;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign data_o = mem_q[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem_q[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			full_o  <= 1'b0;
			empty_o <= 1'b1;
		end else begin
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
			2'b10: begin
				count   <= count + 1'b1;
				full_o  <= (count == CW'(DEPTH - 1));
				empty_o <= 1'b0;
			end
			2'b01: begin
				count   <= count - 1'b1;
				full_o  <= 1'b0;
				empty_o <= (count == CW'(1));
			end
			default: ;   // both or neither, level unchanged
			endcase
		end
	end

	// callers must respect the flags
	a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push_i && full_o));
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: mem_ctrl_pkg.sv
// memory controller types
// request, response and bus command structs plus the
// function and size encodings

`default_nettype none

`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

	// ========================================
	// encodings
	// ========================================
	typedef enum logic [2:0] {
		FN_LOAD  = `MC_F_LOAD,
		FN_LOADZ = `MC_F_LOADZ,
		FN_STORE = `MC_F_STORE,
		FN_LEA   = `MC_F_LEA
	} mem_func_e;

	typedef enum logic [1:0] {
		SZ_B = `MC_SZ_B,
		SZ_W = `MC_SZ_W,
		SZ_T = `MC_SZ_T,
		SZ_O = `MC_SZ_O
	} mem_size_e;

	// ========================================
	// payloads
	// ========================================

	// one queued request, 105 bits
	typedef struct packed {
		logic [`MC_TIDW-1:0] tid;
		mem_func_e           func;   // may carry an unknown code
		mem_size_e           size;
		logic [`MC_AWID-1:0] adr;
		logic [`MC_DWID-1:0] dat;    // store data, right aligned
	} mem_req_t;

	// one queued response, 69 bits
	typedef struct packed {
		logic [`MC_TIDW-1:0] tid;
		logic                fault;  // unimplemented operation
		logic [`MC_DWID-1:0] res;
	} mem_resp_t;

	// bus command toward the slave, 107 bits
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [`MC_SELW-1:0] sel;
		logic [`MC_AWID-1:0] adr;    // always word aligned
		logic [`MC_DWID-1:0] dat;
	} bus_cmd_t;

endpackage

`default_nettype wire

// File: mem_ctrl_params.svh
// load/store memory controller parameters
// bus widths, queue depth, function and size codes

`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// ========================================
// widths
// ========================================
`define MC_AWID    32    // byte address
`define MC_DWID    64    // bus word and result
`define MC_SELW    8     // one lane per byte
`define MC_TIDW    4     // transaction id

`define MC_QDEPTH  4     // entries per queue

// ========================================
// function codes, anything else faults
// ========================================
`define MC_F_LOAD  3'd0  // sign extended
`define MC_F_LOADZ 3'd1  // zero extended
`define MC_F_STORE 3'd2
`define MC_F_LEA   3'd3  // address only, no bus cycle

// access sizes
`define MC_SZ_B    2'd0  // byte
`define MC_SZ_W    2'd1  // wyde
`define MC_SZ_T    2'd2  // tetra
`define MC_SZ_O    2'd3  // octa

`endif
